// File: common/x86_pkg.sv
// Shared types, enums, records and queue constants of the x86 front end
package x86_pkg;

    typedef logic [15:0] word_t;       // Data or offset
    typedef logic [19:0] phys_addr_t;  // Segment * 16 + offset

    // Instruction queue
    localparam int QUEUE_BYTES = 6;
    typedef logic [8*QUEUE_BYTES-1:0] queue_t;  // Byte 0 is the head

    // --------------------------------------------------
    // Enums
    // --------------------------------------------------
    typedef enum logic [2:0] {
        SEG_ES = 3'd0,
        SEG_CS = 3'd1,
        SEG_SS = 3'd2,
        SEG_DS = 3'd3,
        SEG_FS = 3'd4,
        SEG_GS = 3'd5
    } seg_e;

    // Prefix bytes that the decoder recognizes
    typedef enum logic [7:0] {
        PFX_ES = 8'h26,
        PFX_CS = 8'h2E,
        PFX_SS = 8'h36,
        PFX_DS = 8'h3E,
        PFX_FS = 8'h64,
        PFX_GS = 8'h65,
        PFX_0F = 8'h0F   // Opcode extension
    } prefix_e;

    typedef enum logic [2:0] {
        FETCH          = 3'd0,
        DECODE         = 3'd1,
        READ_DATA      = 3'd2,
        READ_DATA_WIDE = 3'd3,  // Second half of unaligned word
        ISSUE          = 3'd4
    } state_e;

    // --------------------------------------------------
    // Records
    // --------------------------------------------------
    typedef struct packed {
        word_t [5:0] sreg;  // Indexed by seg_e
        word_t [7:0] gpr;   // AX CX DX BX SP BP SI DI
    } regs_t;

    typedef struct packed {
        logic       is_segment;
        logic [2:0] index;
        word_t      data;
    } reg_write_t;

    typedef struct packed {
        logic       is_prefix;
        logic       is_0f;
        logic       is_override;
        seg_e       override;    // Segment named by an override byte
        logic       has_modrm;
        logic [2:0] length;
    } decode_t;

    typedef struct packed {
        logic override;
        seg_e seg;
        logic is_0f;
    } prefix_state_t;

    typedef struct packed {
        logic  is_memory;
        word_t segment;   // Segment register value
        word_t offset;
        word_t rm_val;
        word_t reg_val;
    } ea_t;

    typedef struct packed {
        word_t      ip;
        logic [7:0] opcode;
        logic [7:0] modrm;
        word_t      op1;
        word_t      op2;
        logic [2:0] length;      // Opcode and operands, no prefixes
        logic       has_memory;
        logic       is_0f;
        logic       is_override;
        seg_e       seg;
    } issue_t;

endpackage

// File: decode/ea_calc.sv
// ModRM effective address, segment choice and register operand select
`timescale 1ns/100ps

module ea_calc (
    input  x86_pkg::queue_t        i_queue,
    input  x86_pkg::regs_t         i_regs,
    input  x86_pkg::prefix_state_t i_prefix,
    output x86_pkg::ea_t           o_ea
);
    import x86_pkg::*;

    // General register codes
    localparam logic [2:0] R_BX = 3'd3;
    localparam logic [2:0] R_BP = 3'd5;
    localparam logic [2:0] R_SI = 3'd6;
    localparam logic [2:0] R_DI = 3'd7;

    logic [7:0] opcode;
    logic [7:0] modrm;
    word_t      disp16;
    word_t      base;
    logic       bp_based;  // Defaults to SS
    seg_e       seg;

    // Word register, or AL CL DL BL AH CH DH BH for byte forms
    function automatic word_t pick_reg(input regs_t regs, input logic [2:0] idx,
                                       input logic wide);
        word_t src;
        src = regs.gpr[{1'b0, idx[1:0]}];
        if (wide) begin
            return regs.gpr[idx];
        end
        return {8'h00, idx[2] ? src[15:8] : src[7:0]};
    endfunction

    assign opcode = i_queue[7:0];
    assign modrm  = i_queue[15:8];
    assign disp16 = i_queue[31:16];

    always_comb begin
        bp_based = 1'b0;
        case (modrm[2:0])
            3'b000: base = i_regs.gpr[R_BX] + i_regs.gpr[R_SI];
            3'b001: base = i_regs.gpr[R_BX] + i_regs.gpr[R_DI];
            3'b010: begin
                base     = i_regs.gpr[R_BP] + i_regs.gpr[R_SI];
                bp_based = 1'b1;
            end
            3'b011: begin
                base     = i_regs.gpr[R_BP] + i_regs.gpr[R_DI];
                bp_based = 1'b1;
            end
            3'b100: base = i_regs.gpr[R_SI];
            3'b101: base = i_regs.gpr[R_DI];
            3'b110: begin
                bp_based = (modrm[7:6] != 2'b00);
                base     = bp_based ? i_regs.gpr[R_BP] : disp16;  // mod 00 is direct
            end
            default: base = i_regs.gpr[R_BX];
        endcase

        seg = i_prefix.override ? i_prefix.seg : (bp_based ? SEG_SS : SEG_DS);

        o_ea.is_memory = (modrm[7:6] != 2'b11);
        o_ea.segment   = i_regs.sreg[seg];
        case (modrm[7:6])
            2'b01:   o_ea.offset = base + {{8{i_queue[23]}}, i_queue[23:16]};  // disp8
            2'b10:   o_ea.offset = base + disp16;
            default: o_ea.offset = base;
        endcase

        o_ea.rm_val  = pick_reg(i_regs, modrm[2:0], opcode[0]);
        o_ea.reg_val = pick_reg(i_regs, modrm[5:3], opcode[0]);
    end

endmodule

// File: decode/opcode_decoder.sv
// Prefix, ModRM presence and instruction length decode of the queue head
`timescale 1ns/100ps

module opcode_decoder (
    input  x86_pkg::queue_t        i_queue,
    input  x86_pkg::prefix_state_t i_prefix,
    output x86_pkg::decode_t       o_decode
);
    import x86_pkg::*;

    logic [7:0] opcode;
    logic [7:0] modrm;
    logic       modrm_base;  // Base table hit
    logic       modrm_ext;   // 0F table hit
    logic [2:0] modrm_len;   // Opcode + ModRM + displacement
    logic [2:0] imm_len;

    assign opcode = i_queue[7:0];
    assign modrm  = i_queue[15:8];

    // --------------------------------------------------
    // ModRM tables
    // --------------------------------------------------
    always_comb begin
        casez (opcode)
            8'b00??_?0??,                 // ALU reg/rm forms
            8'b1000_????,                 // 80-8F group arith, MOV, LEA
            8'b1100_000?,                 // C0-C1
            8'b1100_01??,                 // C4-C7
            8'b1101_00??,                 // D0-D3 shifts
            8'b1101_1???,                 // D8-DF coprocessor
            8'b1111_?11?: modrm_base = 1'b1;  // F6-F7 FE-FF groups
            default:      modrm_base = 1'b0;
        endcase

        // Most of the 0F map has ModRM, so list the exceptions
        casez (opcode)
            8'b0000_01??, 8'b0000_10??, 8'b0000_11?0,
            8'b0011_0???, 8'b0011_10?1, 8'b0011_11??,
            8'b0111_0111, 8'b0111_100?,
            8'b1000_????,                 // Jcc near
            8'b1011_000?, 8'b1011_0010, 8'b1011_100?, 8'b1011_1010,
            8'b1101_1???,
            8'b1111_1111: modrm_ext = 1'b0;
            default:      modrm_ext = 1'b1;
        endcase
    end

    // --------------------------------------------------
    // Length parts
    // --------------------------------------------------
    always_comb begin
        case (modrm[7:6])
            2'b01:   modrm_len = 3'd3;                                // disp8
            2'b10:   modrm_len = 3'd4;                                // disp16
            2'b00:   modrm_len = (modrm[2:0] == 3'b110) ? 3'd4 : 3'd2; // Direct disp16
            default: modrm_len = 3'd2;                                // Register form
        endcase

        // Immediates of 80-83 and C6-C7, word only for 81 and C7
        imm_len = 3'd0;
        if (!i_prefix.is_0f && (opcode[7:2] == 6'b1000_00 || opcode[7:1] == 7'b1100_011)) begin
            imm_len = (opcode == 8'h81 || opcode == 8'hC7) ? 3'd2 : 3'd1;
        end
    end

    // --------------------------------------------------
    // Prefix classification and final length
    // --------------------------------------------------
    always_comb begin
        o_decode          = '0;
        o_decode.override = SEG_DS;
        if (!i_prefix.is_0f) begin  // No prefixes inside the 0F map
            case (opcode)
                PFX_ES, PFX_CS, PFX_SS, PFX_DS: begin
                    o_decode.is_prefix   = 1'b1;
                    o_decode.is_override = 1'b1;
                    o_decode.override    = seg_e'({1'b0, opcode[4:3]});
                end
                PFX_FS, PFX_GS: begin
                    o_decode.is_prefix   = 1'b1;
                    o_decode.is_override = 1'b1;
                    o_decode.override    = seg_e'({2'b10, opcode[0]});
                end
                PFX_0F: begin
                    o_decode.is_prefix = 1'b1;
                    o_decode.is_0f     = 1'b1;
                end
                default: ;
            endcase
        end

        o_decode.has_modrm = i_prefix.is_0f ? modrm_ext : modrm_base;
        if (o_decode.is_prefix || !o_decode.has_modrm) begin
            o_decode.length = 3'd1;
        end else begin
            o_decode.length = modrm_len + imm_len;
        end
    end

endmodule

// File: fetch/instr_queue.sv
// Six-byte instruction queue with fill index, fetch pointer and length shift
`timescale 1ns/100ps

module instr_queue #(
    parameter x86_pkg::word_t RESET_IP = 16'hFFF0
) (
    input  logic            clock,
    input  logic            i_rst_n,
    input  logic            i_fill,
    input  x86_pkg::word_t  i_data,
    input  logic            i_shift,
    input  logic [2:0]      i_length,
    input  x86_pkg::word_t  i_refill_ptr,
    output x86_pkg::queue_t o_queue,
    output x86_pkg::word_t  o_fetch_ptr,
    output logic            o_full
);
    import x86_pkg::*;

    queue_t     queue;
    logic [2:0] fill_idx;   // Next free byte slot
    word_t      fetch_ptr;  // Offset in CS of the next fetch
    logic       one_byte;   // Only a single byte lands this cycle
    logic       load;

    assign o_queue     = queue;
    assign o_fetch_ptr = fetch_ptr;
    assign o_full      = (fill_idx == 3'(QUEUE_BYTES));

    // Odd pointer gives only the high byte, last slot takes only the low byte
    assign one_byte = fetch_ptr[0] || (fill_idx == 3'(QUEUE_BYTES - 1));
    assign load     = i_fill && !o_full;

    // --------------------------------------------------
    // Queue bytes
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (i_shift) begin
            queue <= queue >> (8 * i_length);  // Drop the decoded bytes
        end else if (load) begin
            if (one_byte) begin
                queue[8*fill_idx +: 8] <= fetch_ptr[0] ? i_data[15:8] : i_data[7:0];
            end else begin
                queue[8*fill_idx +: 16] <= i_data;  // Low byte first
            end
        end
    end

    // --------------------------------------------------
    // Fill index and fetch pointer
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            fill_idx  <= '0;  // Empty
            fetch_ptr <= RESET_IP;
        end else if (i_shift) begin
            fill_idx  <= 3'(QUEUE_BYTES) - i_length;
            fetch_ptr <= i_refill_ptr;  // Byte after the old queue tail
        end else if (load) begin
            fill_idx  <= fill_idx + (one_byte ? 3'd1 : 3'd2);
            fetch_ptr <= fetch_ptr + (one_byte ? 16'd1 : 16'd2);
        end
    end

endmodule

// File: logic/reg_file.sv
// General and segment register file with one write-back port
`timescale 1ns/100ps

module reg_file #(
    parameter x86_pkg::word_t RESET_CS = 16'hF000
) (
    input  logic                clock,
    input  logic                i_rst_n,
    input  logic                i_reg_we,
    input  x86_pkg::reg_write_t i_reg_wr,
    output x86_pkg::regs_t      o_regs
);
    import x86_pkg::*;

    regs_t regs;

    assign o_regs = regs;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            regs              <= '0;
            regs.sreg[SEG_CS] <= RESET_CS;  // Code starts at RESET_CS:RESET_IP
        end else if (i_reg_we) begin
            if (!i_reg_wr.is_segment) begin
                regs.gpr[i_reg_wr.index] <= i_reg_wr.data;
            end else if (i_reg_wr.index <= SEG_GS) begin
                regs.sreg[i_reg_wr.index] <= i_reg_wr.data;  // Codes 6 and 7 dropped
            end
        end
    end

endmodule

// File: logic/sequencer.sv
// Front end FSM with IP, prefix state, operand read, address mux and issue port
`timescale 1ns/100ps

module sequencer #(
    parameter x86_pkg::word_t RESET_IP = 16'hFFF0
) (
    input  logic                   clock,
    input  logic                   i_rst_n,
    input  x86_pkg::word_t         i_data,
    input  x86_pkg::queue_t        i_queue,
    input  x86_pkg::word_t         i_fetch_ptr,
    input  logic                   i_full,
    input  x86_pkg::decode_t       i_decode,
    input  x86_pkg::ea_t           i_ea,
    input  x86_pkg::regs_t         i_regs,
    output logic                   o_fill,
    output logic                   o_shift,
    output logic [2:0]             o_length,
    output x86_pkg::word_t         o_refill_ptr,
    output x86_pkg::prefix_state_t o_prefix,
    output x86_pkg::phys_addr_t    o_addr,
    output logic                   o_issue_valid,
    output x86_pkg::issue_t        o_issue
);
    import x86_pkg::*;

    state_e        state;
    word_t         ip;
    prefix_state_t prefix;
    issue_t        work;        // op1 holds reg/m and op2 reg until issue
    issue_t        issue_next;
    word_t         mem_seg;     // Operand segment value
    word_t         mem_off;     // Operand offset
    logic          data_phase;
    logic          mem_form;

    assign o_fill       = (state == FETCH) && !i_full;
    assign o_shift      = (state == DECODE);
    assign o_length     = i_decode.length;
    assign o_refill_ptr = ip + 16'(QUEUE_BYTES);
    assign o_prefix     = prefix;

    assign mem_form   = i_decode.has_modrm && i_ea.is_memory;
    assign data_phase = (state == READ_DATA) || (state == READ_DATA_WIDE);

    // Operand address in read states, code fetch otherwise
    assign o_addr = data_phase ? {mem_seg, 4'h0} + {4'h0, mem_off}
                               : {i_regs.sreg[SEG_CS], 4'h0} + {4'h0, i_fetch_ptr};

    // Direction bit swaps the operands
    always_comb begin
        issue_next = work;
        if (work.opcode[1]) begin
            issue_next.op1 = work.op2;
            issue_next.op2 = work.op1;
        end
    end

    // --------------------------------------------------
    // State, IP and prefix state
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state         <= FETCH;
            ip            <= RESET_IP;
            prefix        <= '0;
            o_issue_valid <= 1'b0;
        end else begin
            o_issue_valid <= (state == ISSUE);  // One pulse per instruction
            case (state)
                FETCH: if (i_full) state <= DECODE;
                DECODE: begin
                    ip <= ip + 16'(i_decode.length);
                    if (i_decode.is_prefix) begin
                        state <= FETCH;  // Prefix is its own queue entry
                        if (i_decode.is_0f) prefix.is_0f <= 1'b1;
                        if (i_decode.is_override) begin
                            prefix.override <= 1'b1;
                            prefix.seg      <= i_decode.override;
                        end
                    end else begin
                        state <= mem_form ? READ_DATA : ISSUE;
                    end
                end
                READ_DATA: begin
                    // Unaligned word needs a second read
                    state <= (work.opcode[0] && mem_off[0]) ? READ_DATA_WIDE : ISSUE;
                end
                READ_DATA_WIDE: state <= ISSUE;
                ISSUE: begin
                    state  <= FETCH;
                    prefix <= '0;  // Prefixes end with their instruction
                end
                default: state <= FETCH;
            endcase
        end
    end

    // --------------------------------------------------
    // Instruction record and operand read
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        case (state)
            DECODE: if (!i_decode.is_prefix) begin
                work.ip          <= ip;
                work.opcode      <= i_queue[7:0];
                work.modrm       <= i_decode.has_modrm ? i_queue[15:8] : 8'h00;
                work.op1         <= i_decode.has_modrm ? i_ea.rm_val : 16'h0000;
                work.op2         <= i_decode.has_modrm ? i_ea.reg_val : 16'h0000;
                work.length      <= i_decode.length;
                work.has_memory  <= mem_form;
                work.is_0f       <= prefix.is_0f;
                work.is_override <= prefix.override;
                work.seg         <= prefix.seg;
                mem_seg          <= i_ea.segment;
                mem_off          <= i_ea.offset;
            end
            READ_DATA: begin
                if (!work.opcode[0]) begin  // Byte from either half
                    work.op1 <= {8'h00, mem_off[0] ? i_data[15:8] : i_data[7:0]};
                end else if (mem_off[0]) begin
                    work.op1 <= {8'h00, i_data[15:8]};  // Low byte, high half
                    mem_off  <= mem_off + 16'd1;        // Next aligned word
                end else begin
                    work.op1 <= i_data;
                end
            end
            READ_DATA_WIDE: work.op1[15:8] <= i_data[7:0];
            ISSUE: o_issue <= issue_next;  // Held until next issue
            default: ;
        endcase
    end

endmodule

// File: logic/x86_front.sv
// Top level of the x86 front end with register file, queue, decode and sequencer
`timescale 1ns/100ps

module x86_front #(
    parameter x86_pkg::word_t RESET_CS = 16'hF000,
    parameter x86_pkg::word_t RESET_IP = 16'hFFF0
) (
    input  logic                 clock,
    input  logic                 i_rst_n,
    input  x86_pkg::word_t       i_data,
    output x86_pkg::phys_addr_t  o_addr,
    input  logic                 i_reg_we,
    input  x86_pkg::reg_write_t  i_reg_wr,
    output logic                 o_issue_valid,
    output x86_pkg::issue_t      o_issue
);
    import x86_pkg::*;

    regs_t         regs;
    queue_t        queue;
    word_t         fetch_ptr;
    logic          full;
    logic          fill;
    logic          shift;
    logic [2:0]    length;
    word_t         refill_ptr;
    prefix_state_t prefix;
    decode_t       decode;
    ea_t           ea;

    reg_file #(
        .RESET_CS (RESET_CS)
    ) i_reg_file (
        .clock    (clock),
        .i_rst_n  (i_rst_n),
        .i_reg_we (i_reg_we),
        .i_reg_wr (i_reg_wr),
        .o_regs   (regs)
    );

    instr_queue #(
        .RESET_IP (RESET_IP)
    ) i_instr_queue (
        .clock        (clock),
        .i_rst_n      (i_rst_n),
        .i_fill       (fill),
        .i_data       (i_data),
        .i_shift      (shift),
        .i_length     (length),
        .i_refill_ptr (refill_ptr),
        .o_queue      (queue),
        .o_fetch_ptr  (fetch_ptr),
        .o_full       (full)
    );

    opcode_decoder i_opcode_decoder (
        .i_queue  (queue),
        .i_prefix (prefix),
        .o_decode (decode)
    );

    ea_calc i_ea_calc (
        .i_queue  (queue),
        .i_regs   (regs),
        .i_prefix (prefix),
        .o_ea     (ea)
    );

    sequencer #(
        .RESET_IP (RESET_IP)
    ) i_sequencer (
        .clock         (clock),
        .i_rst_n       (i_rst_n),
        .i_data        (i_data),
        .i_queue       (queue),
        .i_fetch_ptr   (fetch_ptr),
        .i_full        (full),
        .i_decode      (decode),
        .i_ea          (ea),
        .i_regs        (regs),
        .o_fill        (fill),
        .o_shift       (shift),
        .o_length      (length),
        .o_refill_ptr  (refill_ptr),
        .o_prefix      (prefix),
        .o_addr        (o_addr),
        .o_issue_valid (o_issue_valid),
        .o_issue       (o_issue)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the x86_front simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f x86_front.f --top-module tb_x86_front \
    -o sim_x86_front > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_x86_front > sim.log 2>&1
cat sim.log
grep -qx "=== PASS ===" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tests/tb_x86_front.sv
// Testbench for x86_front with clock, reset, memory model, compare tasks and directed tests
`timescale 1ns/100ps

module tb_x86_front;
    import x86_pkg::*;

    localparam int TIMEOUT = 200;  // Cycles per issue wait

    logic       clock;
    logic       i_rst_n;
    word_t      i_data;
    phys_addr_t o_addr;
    logic       i_reg_we;
    reg_write_t i_reg_wr;
    logic       o_issue_valid;
    issue_t     o_issue;

    logic [7:0] mem [0:1048575];  // Byte memory, 1 MB
    phys_addr_t data_addrs[$];     // Operand addresses seen before an issue

    x86_front #(
        .RESET_CS (16'h0000),
        .RESET_IP (16'h0100)
    ) i_x86_front (
        .clock         (clock),
        .i_rst_n       (i_rst_n),
        .i_data        (i_data),
        .o_addr        (o_addr),
        .i_reg_we      (i_reg_we),
        .i_reg_wr      (i_reg_wr),
        .o_issue_valid (o_issue_valid),
        .o_issue       (o_issue)
    );

    // Aligned word containing o_addr, low byte even
    assign i_data = {mem[{o_addr[19:1], 1'b1}], mem[{o_addr[19:1], 1'b0}]};

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic compare_issue(input string name, input issue_t got, input issue_t exp);
        issue_t g;
        issue_t e;
        g = got;
        e = exp;
        if (!e.is_override) begin  // Segment field only meaningful with override
            g.seg = SEG_ES;
            e.seg = SEG_ES;
        end
        if (g !== e) begin
            report_failure($sformatf("ERROR at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_addr(input string name, input phys_addr_t got,
                                input phys_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    function automatic issue_t make_issue(input word_t ip, input logic [7:0] opcode,
                                          input logic [7:0] modrm, input word_t op1,
                                          input word_t op2, input logic [2:0] len,
                                          input logic has_mem, input logic is_0f,
                                          input logic ovr, input seg_e seg);
        issue_t r;
        r.ip          = ip;
        r.opcode      = opcode;
        r.modrm       = modrm;
        r.op1         = op1;
        r.op2         = op2;
        r.length      = len;
        r.has_memory  = has_mem;
        r.is_0f       = is_0f;
        r.is_override = ovr;
        r.seg         = seg;
        return r;
    endfunction

    function automatic word_t mem_word(input phys_addr_t a);
        return {mem[a + 20'd1], mem[a]};
    endfunction

    // Collects operand addresses, returns the issued record
    task automatic wait_issue(output issue_t rec);
        int cycles;
        data_addrs.delete();
        for (cycles = 0; cycles < TIMEOUT; cycles++) begin
            @(negedge clock);
            if (o_addr >= 20'h10000) data_addrs.push_back(o_addr);  // Above code area
            if (o_issue_valid) begin
                rec = o_issue;
                return;
            end
        end
        report_failure("Timed out waiting for o_issue_valid");
    endtask

    task automatic check_reads(input string name, input phys_addr_t a0,
                               input phys_addr_t a1, input int count);
        if (data_addrs.size() != count) begin
            report_failure($sformatf("%s made %0d operand reads instead of %0d",
                                     name, data_addrs.size(), count));
        end
        compare_addr({name, " o_addr"}, data_addrs[0], a0);
        if (count == 2) compare_addr({name, " o_addr second"}, data_addrs[1], a1);
    endtask

    task automatic write_reg(input logic is_seg, input logic [2:0] idx, input word_t data);
        @(negedge clock);
        i_reg_we            = 1'b1;
        i_reg_wr.is_segment = is_seg;
        i_reg_wr.index      = idx;
        i_reg_wr.data       = data;
    endtask

    // Registers land before the first register form decodes
    task automatic load_registers();
        write_reg(1'b0, 3'd0, 16'h1234);  // AX
        write_reg(1'b0, 3'd1, 16'h5678);  // CX
        write_reg(1'b0, 3'd3, 16'h9ABC);  // BX
        write_reg(1'b0, 3'd5, 16'h0010);  // BP
        write_reg(1'b1, 3'(SEG_DS), 16'h2000);
        write_reg(1'b1, 3'(SEG_ES), 16'h3000);
        write_reg(1'b1, 3'(SEG_FS), 16'h4000);
        write_reg(1'b1, 3'(SEG_SS), 16'h5000);
        @(negedge clock);  // Last write takes its edge
        i_reg_we = 1'b0;
    endtask

    task automatic load_program();
        byte unsigned code[] = '{8'h90, 8'h40, 8'h90, 8'h01, 8'hC8, 8'h00, 8'hE1,
            8'h89, 8'h06, 8'h00, 8'h01, 8'h89, 8'h06, 8'h01, 8'h01,
            8'h26, 8'h89, 8'h06, 8'h00, 8'h01, 8'h64, 8'h88, 8'h46, 8'h02,
            8'h89, 8'h46, 8'h04, 8'h81, 8'h46, 8'h02, 8'h34, 8'h12,
            8'h83, 8'hC1, 8'h05, 8'h0F, 8'h80, 8'h0F, 8'hB6, 8'hC3, 8'h90};
        for (int a = 0; a < 1048576; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ {2{4'(a >> 16)}};  // Whole address pattern
        end
        foreach (code[i]) mem[20'h00100 + i] = code[i];
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_one_byte_ops();
        issue_t rec;
        wait_issue(rec);
        compare_issue("nop 0100", rec, make_issue(16'h0100, 8'h90, 0, 0, 0, 1, 0, 0, 0, SEG_ES));
        wait_issue(rec);
        compare_issue("inc 0101", rec, make_issue(16'h0101, 8'h40, 0, 0, 0, 1, 0, 0, 0, SEG_ES));
        wait_issue(rec);
        compare_issue("nop 0102", rec, make_issue(16'h0102, 8'h90, 0, 0, 0, 1, 0, 0, 0, SEG_ES));
    endtask

    task automatic test_register_forms();
        issue_t rec;
        wait_issue(rec);  // op1 AX, op2 CX
        compare_issue("add 01 C8", rec,
                      make_issue(16'h0103, 8'h01, 8'hC8, 16'h1234, 16'h5678, 2, 0, 0, 0, SEG_ES));
        wait_issue(rec);  // op1 CL, op2 AH
        compare_issue("add 00 E1", rec,
                      make_issue(16'h0105, 8'h00, 8'hE1, 16'h0078, 16'h0012, 2, 0, 0, 0, SEG_ES));
    endtask

    task automatic test_direct_disp();
        issue_t rec;
        wait_issue(rec);
        check_reads("mov even", 20'h20100, 0, 1);
        compare_issue("mov even", rec, make_issue(16'h0107, 8'h89, 8'h06, mem_word(20'h20100),
                                                  16'h1234, 4, 1, 0, 0, SEG_ES));
        wait_issue(rec);
        check_reads("mov odd", 20'h20101, 20'h20102, 2);
        compare_issue("mov odd", rec, make_issue(16'h010B, 8'h89, 8'h06, mem_word(20'h20101),
                                                 16'h1234, 4, 1, 0, 0, SEG_ES));
    endtask

    task automatic test_segment_override();
        issue_t rec;
        wait_issue(rec);
        check_reads("es mov", 20'h30100, 0, 1);
        compare_issue("es mov", rec, make_issue(16'h0110, 8'h89, 8'h06, mem_word(20'h30100),
                                                16'h1234, 4, 1, 0, 1, SEG_ES));
        wait_issue(rec);  // FS:BP+2 byte
        check_reads("fs mov", 20'h40012, 0, 1);
        compare_issue("fs mov", rec, make_issue(16'h0115, 8'h88, 8'h46,
                                                {8'h00, mem[20'h40012]}, 16'h0034,
                                                3, 1, 0, 1, SEG_FS));
        wait_issue(rec);  // BP base defaults to SS
        check_reads("ss mov", 20'h50014, 0, 1);
        compare_issue("ss mov", rec, make_issue(16'h0118, 8'h89, 8'h46, mem_word(20'h50014),
                                                16'h1234, 3, 1, 0, 0, SEG_ES));
    endtask

    task automatic test_immediate_lengths();
        issue_t rec;
        wait_issue(rec);
        check_reads("81 /0", 20'h50012, 0, 1);
        compare_issue("81 /0", rec, make_issue(16'h011B, 8'h81, 8'h46, mem_word(20'h50012),
                                               16'h1234, 5, 1, 0, 0, SEG_ES));
        wait_issue(rec);  // ip 0120 proves length 5, bit 1 puts reg AX first
        compare_issue("83 /0", rec,
                      make_issue(16'h0120, 8'h83, 8'hC1, 16'h1234, 16'h5678, 3, 0, 0, 0, SEG_ES));
    endtask

    task automatic test_0f_map();
        issue_t rec;
        wait_issue(rec);  // ip 0124 proves length 3 above
        compare_issue("0F 80", rec, make_issue(16'h0124, 8'h80, 0, 0, 0, 1, 0, 1, 0, SEG_ES));
        wait_issue(rec);  // op1 AL, op2 BL
        compare_issue("0F B6", rec,
                      make_issue(16'h0126, 8'hB6, 8'hC3, 16'h0034, 16'h00BC, 2, 0, 1, 0, SEG_ES));
        wait_issue(rec);  // Prefix state cleared again
        compare_issue("nop 0128", rec, make_issue(16'h0128, 8'h90, 0, 0, 0, 1, 0, 0, 0, SEG_ES));
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        i_rst_n  = 1'b0;
        i_reg_we = 1'b0;
        i_reg_wr = '0;
        load_program();
        repeat (8) @(negedge clock);
        i_rst_n = 1'b1;
        // Front end runs at once, so registers load beside the first issues
        fork
            load_registers();
            test_one_byte_ops();
        join
        test_register_forms();
        test_direct_disp();
        test_segment_override();
        test_immediate_lengths();
        test_0f_map();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tests/x86_front_props.sv
// Concurrent assertions on the sequencer issue pulse and state encoding
`timescale 1ns/100ps

module x86_front_props (
    input logic              clock,
    input logic              i_rst_n,
    input logic              o_issue_valid,
    input x86_pkg::state_e   state
);
    import x86_pkg::*;

    // Issue strobe is a single-cycle pulse
    assert property (@(posedge clock) disable iff (!i_rst_n)
        o_issue_valid |=> !o_issue_valid)
        else $error("o_issue_valid high two cycles in a row");

    // Reset clears the strobe
    assert property (@(posedge clock) !i_rst_n |=> !o_issue_valid)
        else $error("o_issue_valid high after a reset cycle");

    // State register only holds encoded FSM states
    assert property (@(posedge clock) disable iff (!i_rst_n)
        state inside {FETCH, DECODE, READ_DATA, READ_DATA_WIDE, ISSUE})
        else $error("sequencer state outside state_e");

endmodule

bind sequencer x86_front_props i_x86_front_props (
    .clock         (clock),
    .i_rst_n       (i_rst_n),
    .o_issue_valid (o_issue_valid),
    .state         (state)
);

// File: x86_front.f
common/x86_pkg.sv
logic/reg_file.sv
fetch/instr_queue.sv
decode/opcode_decoder.sv
decode/ea_calc.sv
logic/sequencer.sv
logic/x86_front.sv
tests/x86_front_props.sv
tests/tb_x86_front.sv
